//--- common/mem_bus_pkg.sv
package mem_bus_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    // one strobe bit per data byte
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [RESP_W-1:0] resp_t;

    // response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // read arbiter owner
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_LSU,
        ARB_FETCH
    } arb_state_e;

endpackage

//--- common/mem_map_pkg.sv
package mem_map_pkg;

    // first byte of the memory window
    localparam mem_bus_pkg::addr_t MEM_BASE = 32'h8000_0000;

    // window depth in 64-bit words
    localparam int MEM_WORDS = 1024;

    localparam int WORD_IDX_W = $clog2(MEM_WORDS);

    typedef logic [WORD_IDX_W-1:0] word_idx_t;

endpackage

//--- arbiter/read_arbiter.sv
`timescale 1ns/1ns

module read_arbiter (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               fetch_ar_valid_i,
    input  mem_bus_pkg::addr_t fetch_ar_addr_i,
    input  logic               fetch_r_ready_i,
    input  logic               lsu_ar_valid_i,
    input  mem_bus_pkg::addr_t lsu_ar_addr_i,
    input  logic               lsu_r_ready_i,
    input  logic               mem_ar_ready_i,
    input  logic               mem_r_valid_i,
    input  mem_bus_pkg::resp_t mem_r_resp_i,
    input  mem_bus_pkg::data_t mem_r_data_i,
    output logic               fetch_ar_ready_o,
    output logic               fetch_r_valid_o,
    output mem_bus_pkg::resp_t fetch_r_resp_o,
    output mem_bus_pkg::data_t fetch_r_data_o,
    output logic               lsu_ar_ready_o,
    output logic               lsu_r_valid_o,
    output mem_bus_pkg::resp_t lsu_r_resp_o,
    output mem_bus_pkg::data_t lsu_r_data_o,
    output logic               mem_ar_valid_o,
    output mem_bus_pkg::addr_t mem_ar_addr_o,
    output logic               mem_r_ready_o
);

    mem_bus_pkg::arb_state_e state_q;
    mem_bus_pkg::arb_state_e state_d;
    logic                    ar_fire;
    logic                    r_fire;

    assign ar_fire = mem_ar_valid_o && mem_ar_ready_i;
    assign r_fire  = mem_r_valid_i && mem_r_ready_o;

    // ************************************************************
    // request side, only open while idle
    // ************************************************************
    always_comb begin
        mem_ar_valid_o   = 1'b0;
        lsu_ar_ready_o   = 1'b0;
        fetch_ar_ready_o = 1'b0;
        // lsu address wins when both ask
        mem_ar_addr_o    = lsu_ar_valid_i ? lsu_ar_addr_i : fetch_ar_addr_i;
        if (state_q == mem_bus_pkg::ARB_IDLE) begin
            mem_ar_valid_o   = lsu_ar_valid_i || fetch_ar_valid_i;
            lsu_ar_ready_o   = mem_ar_ready_i;
            fetch_ar_ready_o = mem_ar_ready_i && !lsu_ar_valid_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_bus_pkg::ARB_IDLE: begin
                if (ar_fire) begin
                    state_d = lsu_ar_valid_i ? mem_bus_pkg::ARB_LSU : mem_bus_pkg::ARB_FETCH;
                end
            end
            mem_bus_pkg::ARB_LSU, mem_bus_pkg::ARB_FETCH: begin
                // owner keeps the channel until its r handshake
                if (r_fire) begin
                    state_d = mem_bus_pkg::ARB_IDLE;
                end
            end
            default: state_d = mem_bus_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= mem_bus_pkg::ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ************************************************************
    // response side, valid steered to the owner only
    // ************************************************************
    assign lsu_r_valid_o   = (state_q == mem_bus_pkg::ARB_LSU) && mem_r_valid_i;
    assign fetch_r_valid_o = (state_q == mem_bus_pkg::ARB_FETCH) && mem_r_valid_i;
    assign mem_r_ready_o   = (state_q == mem_bus_pkg::ARB_LSU)   ? lsu_r_ready_i :
                             (state_q == mem_bus_pkg::ARB_FETCH) ? fetch_r_ready_i : 1'b0;

    // payload goes to both, qualified by valid
    assign lsu_r_resp_o   = mem_r_resp_i;
    assign lsu_r_data_o   = mem_r_data_i;
    assign fetch_r_resp_o = mem_r_resp_i;
    assign fetch_r_data_o = mem_r_data_i;

    // slave only answers a read that some master owns
    a_r_has_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_r_valid_i |-> state_q != mem_bus_pkg::ARB_IDLE)
        else $error("read response with no owner in ARB_IDLE");

    a_hold_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
        (state_q != mem_bus_pkg::ARB_IDLE) && !r_fire |=> state_q == $past(state_q))
        else $error("arbiter left ARB_LSU/ARB_FETCH without r handshake");

endmodule

//--- sram/sram_array.sv
`timescale 1ns/1ns

module sram_array (
    input  logic                   clk,
    input  logic                   rd_en_i,
    input  mem_map_pkg::word_idx_t rd_idx_i,
    input  logic                   wr_en_i,
    input  mem_map_pkg::word_idx_t wr_idx_i,
    input  mem_bus_pkg::data_t     wr_data_i,
    input  mem_bus_pkg::strb_t     wr_strb_i,
    output mem_bus_pkg::data_t     rd_data_o
);

    mem_bus_pkg::data_t mem [mem_map_pkg::MEM_WORDS];

    initial begin
        for (int i = 0; i < mem_map_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // byte lanes written only where the strobe is set
    always @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
                if (wr_strb_i[b]) begin
                    mem[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // same-cycle write is not visible, old word comes back
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_idx_i];
        end
    end

endmodule

//--- sram/sram_ctrl.sv
`timescale 1ns/1ns

module sram_ctrl (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   ar_valid_i,
    input  mem_bus_pkg::addr_t     ar_addr_i,
    input  logic                   r_ready_i,
    input  logic                   aw_valid_i,
    input  mem_bus_pkg::addr_t     aw_addr_i,
    input  logic                   w_valid_i,
    input  mem_bus_pkg::data_t     w_data_i,
    input  mem_bus_pkg::strb_t     w_strb_i,
    input  logic                   b_ready_i,
    input  mem_bus_pkg::data_t     rd_data_i,
    output logic                   ar_ready_o,
    output logic                   r_valid_o,
    output mem_bus_pkg::resp_t     r_resp_o,
    output mem_bus_pkg::data_t     r_data_o,
    output logic                   aw_ready_o,
    output logic                   w_ready_o,
    output logic                   b_valid_o,
    output mem_bus_pkg::resp_t     b_resp_o,
    output logic                   rd_en_o,
    output mem_map_pkg::word_idx_t rd_idx_o,
    output logic                   wr_en_o,
    output mem_map_pkg::word_idx_t wr_idx_o,
    output mem_bus_pkg::data_t     wr_data_o,
    output mem_bus_pkg::strb_t     wr_strb_o
);

    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    rd_state_e              rd_state_q;
    wr_state_e              wr_state_q;
    logic                   ar_fire;
    logic                   r_fire;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   b_fire;
    logic                   ar_in_win;
    logic                   rd_hit_q;
    logic                   wr_hit_q;
    mem_map_pkg::word_idx_t wr_idx_q;

    // true when addr falls in [MEM_BASE, MEM_BASE + window)
    function automatic logic in_window(mem_bus_pkg::addr_t addr);
        mem_bus_pkg::addr_t offset;
        offset = addr - mem_map_pkg::MEM_BASE;
        return offset < mem_bus_pkg::addr_t'(mem_map_pkg::MEM_WORDS * mem_bus_pkg::STRB_W);
    endfunction

    assign ar_fire = ar_valid_i && ar_ready_o;
    assign r_fire  = r_valid_o && r_ready_i;
    assign aw_fire = aw_valid_i && aw_ready_o;
    assign w_fire  = w_valid_i && w_ready_o;
    assign b_fire  = b_valid_o && b_ready_i;

    // ************************************************************
    // read channel
    // ************************************************************
    assign ar_in_win = in_window(ar_addr_i);
    assign rd_en_o   = ar_fire && ar_in_win;
    // byte offset bits dropped
    assign rd_idx_o  = ar_addr_i[mem_map_pkg::WORD_IDX_W+2:3];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_state_q <= RD_IDLE;
            rd_hit_q   <= 1'b0;
        end else begin
            case (rd_state_q)
                RD_IDLE: begin
                    if (ar_fire) begin
                        rd_state_q <= RD_RESP;
                        rd_hit_q   <= ar_in_win;
                    end
                end
                RD_RESP: begin
                    if (r_fire) begin
                        rd_state_q <= RD_IDLE;
                    end
                end
                default: rd_state_q <= RD_IDLE;
            endcase
        end
    end

    assign ar_ready_o = (rd_state_q == RD_IDLE);
    assign r_valid_o  = (rd_state_q == RD_RESP);
    // array holds its word until the next rd_en
    assign r_data_o   = rd_hit_q ? rd_data_i : '0;
    assign r_resp_o   = rd_hit_q ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;

    // ************************************************************
    // write channel, aw then w then b
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_state_q <= WR_IDLE;
            wr_hit_q   <= 1'b0;
        end else begin
            case (wr_state_q)
                WR_IDLE: begin
                    if (aw_fire) begin
                        wr_state_q <= WR_DATA;
                        wr_hit_q   <= in_window(aw_addr_i);
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        wr_state_q <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        wr_state_q <= WR_IDLE;
                    end
                end
                default: wr_state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx_q <= aw_addr_i[mem_map_pkg::WORD_IDX_W+2:3];
        end
    end

    assign aw_ready_o = (wr_state_q == WR_IDLE);
    assign w_ready_o  = (wr_state_q == WR_DATA);
    assign b_valid_o  = (wr_state_q == WR_RESP);
    assign b_resp_o   = wr_hit_q ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;

    // outside writes never reach the array
    assign wr_en_o   = w_fire && wr_hit_q;
    assign wr_idx_o  = wr_idx_q;
    assign wr_data_o = w_data_i;
    assign wr_strb_o = w_strb_i;

    a_r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
        else $error("r channel changed while stalled");

    a_b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
        else $error("b channel changed while stalled");

endmodule

//--- logic/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys (
    input  logic               clk,
    input  logic               arst_n_i,
    // fetch read
    input  logic               fetch_ar_valid_i,
    output logic               fetch_ar_ready_o,
    input  mem_bus_pkg::addr_t fetch_ar_addr_i,
    output logic               fetch_r_valid_o,
    input  logic               fetch_r_ready_i,
    output mem_bus_pkg::resp_t fetch_r_resp_o,
    output mem_bus_pkg::data_t fetch_r_data_o,
    // load/store read
    input  logic               lsu_ar_valid_i,
    output logic               lsu_ar_ready_o,
    input  mem_bus_pkg::addr_t lsu_ar_addr_i,
    output logic               lsu_r_valid_o,
    input  logic               lsu_r_ready_i,
    output mem_bus_pkg::resp_t lsu_r_resp_o,
    output mem_bus_pkg::data_t lsu_r_data_o,
    // load/store write
    input  logic               lsu_aw_valid_i,
    output logic               lsu_aw_ready_o,
    input  mem_bus_pkg::addr_t lsu_aw_addr_i,
    input  logic               lsu_w_valid_i,
    output logic               lsu_w_ready_o,
    input  mem_bus_pkg::data_t lsu_w_data_i,
    input  mem_bus_pkg::strb_t lsu_w_strb_i,
    output logic               lsu_b_valid_o,
    input  logic               lsu_b_ready_i,
    output mem_bus_pkg::resp_t lsu_b_resp_o
);

    // arbiter <> controller read channel
    logic                   mem_ar_valid;
    logic                   mem_ar_ready;
    mem_bus_pkg::addr_t     mem_ar_addr;
    logic                   mem_r_valid;
    logic                   mem_r_ready;
    mem_bus_pkg::resp_t     mem_r_resp;
    mem_bus_pkg::data_t     mem_r_data;

    // controller <> array
    logic                   rd_en;
    mem_map_pkg::word_idx_t rd_idx;
    mem_bus_pkg::data_t     rd_data;
    logic                   wr_en;
    mem_map_pkg::word_idx_t wr_idx;
    mem_bus_pkg::data_t     wr_data;
    mem_bus_pkg::strb_t     wr_strb;

    // ************************************************************
    // read arbitration, lsu first
    // ************************************************************
    read_arbiter u_read_arbiter (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .fetch_ar_valid_i (fetch_ar_valid_i),
        .fetch_ar_addr_i  (fetch_ar_addr_i),
        .fetch_r_ready_i  (fetch_r_ready_i),
        .lsu_ar_valid_i   (lsu_ar_valid_i),
        .lsu_ar_addr_i    (lsu_ar_addr_i),
        .lsu_r_ready_i    (lsu_r_ready_i),
        .mem_ar_ready_i   (mem_ar_ready),
        .mem_r_valid_i    (mem_r_valid),
        .mem_r_resp_i     (mem_r_resp),
        .mem_r_data_i     (mem_r_data),
        .fetch_ar_ready_o (fetch_ar_ready_o),
        .fetch_r_valid_o  (fetch_r_valid_o),
        .fetch_r_resp_o   (fetch_r_resp_o),
        .fetch_r_data_o   (fetch_r_data_o),
        .lsu_ar_ready_o   (lsu_ar_ready_o),
        .lsu_r_valid_o    (lsu_r_valid_o),
        .lsu_r_resp_o     (lsu_r_resp_o),
        .lsu_r_data_o     (lsu_r_data_o),
        .mem_ar_valid_o   (mem_ar_valid),
        .mem_ar_addr_o    (mem_ar_addr),
        .mem_r_ready_o    (mem_r_ready)
    );

    // ************************************************************
    // slave, write channels straight from the lsu
    // ************************************************************
    sram_ctrl u_sram_ctrl (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ar_valid_i (mem_ar_valid),
        .ar_addr_i  (mem_ar_addr),
        .r_ready_i  (mem_r_ready),
        .aw_valid_i (lsu_aw_valid_i),
        .aw_addr_i  (lsu_aw_addr_i),
        .w_valid_i  (lsu_w_valid_i),
        .w_data_i   (lsu_w_data_i),
        .w_strb_i   (lsu_w_strb_i),
        .b_ready_i  (lsu_b_ready_i),
        .rd_data_i  (rd_data),
        .ar_ready_o (mem_ar_ready),
        .r_valid_o  (mem_r_valid),
        .r_resp_o   (mem_r_resp),
        .r_data_o   (mem_r_data),
        .aw_ready_o (lsu_aw_ready_o),
        .w_ready_o  (lsu_w_ready_o),
        .b_valid_o  (lsu_b_valid_o),
        .b_resp_o   (lsu_b_resp_o),
        .rd_en_o    (rd_en),
        .rd_idx_o   (rd_idx),
        .wr_en_o    (wr_en),
        .wr_idx_o   (wr_idx),
        .wr_data_o  (wr_data),
        .wr_strb_o  (wr_strb)
    );

    sram_array u_sram_array (
        .clk       (clk),
        .rd_en_i   (rd_en),
        .rd_idx_i  (rd_idx),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data),
        .wr_strb_i (wr_strb),
        .rd_data_o (rd_data)
    );

endmodule

//--- verif/tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys;

    localparam int WAIT_LIMIT = 64;
    localparam mem_bus_pkg::addr_t WINDOW_BYTES =
        mem_bus_pkg::addr_t'(mem_map_pkg::MEM_WORDS * 8);

    logic clk;
    logic arst_n_i;
    logic fetch_ar_valid_i, fetch_ar_ready_o, fetch_r_valid_o, fetch_r_ready_i;
    logic lsu_ar_valid_i, lsu_ar_ready_o, lsu_r_valid_o, lsu_r_ready_i;
    logic lsu_aw_valid_i, lsu_aw_ready_o, lsu_w_valid_i, lsu_w_ready_o;
    logic lsu_b_valid_o, lsu_b_ready_i;
    mem_bus_pkg::addr_t fetch_ar_addr_i, lsu_ar_addr_i, lsu_aw_addr_i;
    mem_bus_pkg::data_t fetch_r_data_o, lsu_r_data_o, lsu_w_data_i;
    mem_bus_pkg::resp_t fetch_r_resp_o, lsu_r_resp_o, lsu_b_resp_o;
    mem_bus_pkg::strb_t lsu_w_strb_i;

    // reference memory and the responses expected next
    mem_bus_pkg::data_t ref_mem [mem_map_pkg::MEM_WORDS];
    mem_bus_pkg::data_t lsu_exp_data, fetch_exp_data;
    mem_bus_pkg::resp_t lsu_exp_resp, fetch_exp_resp, exp_b_resp;
    mem_bus_pkg::addr_t written[$];
    logic race, lsu_r_seen;
    string test_name;
    int err_cnt, test_err_base, pass_cnt, fail_cnt;

    mem_subsys uut (.*);

    always #20 clk = ~clk;

    // ************************************************************
    // handshake checks
    // ************************************************************
    a_lsu_r_value: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_r_valid_o && lsu_r_ready_i |-> lsu_r_data_o == lsu_exp_data
            && lsu_r_resp_o == lsu_exp_resp)
    else begin
        err_cnt++;
        $display("mismatch in %s: lsu read expected %h resp %0d, actual %h resp %0d",
            test_name, $sampled(lsu_exp_data), $sampled(lsu_exp_resp),
            $sampled(lsu_r_data_o), $sampled(lsu_r_resp_o));
    end

    a_fetch_r_value: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_r_valid_o && fetch_r_ready_i |-> fetch_r_data_o == fetch_exp_data
            && fetch_r_resp_o == fetch_exp_resp)
    else begin
        err_cnt++;
        $display("mismatch in %s: fetch read expected %h resp %0d, actual %h resp %0d",
            test_name, $sampled(fetch_exp_data), $sampled(fetch_exp_resp),
            $sampled(fetch_r_data_o), $sampled(fetch_r_resp_o));
    end

    a_b_value: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_b_valid_o && lsu_b_ready_i |-> lsu_b_resp_o == exp_b_resp)
    else begin
        err_cnt++;
        $display("mismatch in %s: write response expected %0d, actual %0d",
            test_name, $sampled(exp_b_resp), $sampled(lsu_b_resp_o));
    end

    // one cycle from handshake to response
    a_lsu_r_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_ar_valid_i && lsu_ar_ready_o |=> lsu_r_valid_o)
    else begin
        err_cnt++;
        $display("lsu read response did not follow its request by one cycle in %s", test_name);
    end

    a_fetch_r_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_ar_valid_i && fetch_ar_ready_o |=> fetch_r_valid_o)
    else begin
        err_cnt++;
        $display("fetch read response did not follow its request by one cycle in %s", test_name);
    end

    a_b_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_w_valid_i && lsu_w_ready_o |=> lsu_b_valid_o)
    else begin
        err_cnt++;
        $display("write response did not follow the write data by one cycle in %s", test_name);
    end

    a_lsu_r_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_r_valid_o && !lsu_r_ready_i |=> lsu_r_valid_o && $stable(lsu_r_data_o)
            && $stable(lsu_r_resp_o))
    else begin
        err_cnt++;
        $display("lsu read response changed while stalled in %s", test_name);
    end

    a_fetch_r_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_r_valid_o && !fetch_r_ready_i |=> fetch_r_valid_o && $stable(fetch_r_data_o)
            && $stable(fetch_r_resp_o))
    else begin
        err_cnt++;
        $display("fetch read response changed while stalled in %s", test_name);
    end

    a_b_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_b_valid_o && !lsu_b_ready_i |=> lsu_b_valid_o && $stable(lsu_b_resp_o))
    else begin
        err_cnt++;
        $display("write response changed while stalled in %s", test_name);
    end

    // lsu wins a tie and is answered first
    a_lsu_first: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_ar_valid_i && fetch_ar_valid_i |-> !fetch_ar_ready_o)
    else begin
        err_cnt++;
        $display("fetch was granted while lsu was requesting in %s", test_name);
    end

    a_race_order: assert property (@(posedge clk) disable iff (!arst_n_i)
        race && fetch_r_valid_o |-> lsu_r_seen)
    else begin
        err_cnt++;
        $display("fetch was answered before the lsu in %s", test_name);
    end

    // ************************************************************
    // reference model
    // ************************************************************
    function automatic logic addr_mapped(input mem_bus_pkg::addr_t addr);
        return addr >= mem_map_pkg::MEM_BASE && addr < mem_map_pkg::MEM_BASE + WINDOW_BYTES;
    endfunction

    function automatic mem_map_pkg::word_idx_t word_of(input mem_bus_pkg::addr_t addr);
        return mem_map_pkg::word_idx_t'((addr - mem_map_pkg::MEM_BASE) >> 3);
    endfunction

    function automatic mem_bus_pkg::data_t expect_data(input mem_bus_pkg::addr_t addr);
        return addr_mapped(addr) ? ref_mem[word_of(addr)] : '0;
    endfunction

    function automatic mem_bus_pkg::resp_t expect_resp(input mem_bus_pkg::addr_t addr);
        return addr_mapped(addr) ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
    endfunction

    function automatic mem_bus_pkg::data_t merge_bytes(input mem_bus_pkg::data_t old_word,
            input mem_bus_pkg::data_t new_word, input mem_bus_pkg::strb_t strb);
        mem_bus_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic mem_bus_pkg::addr_t rand_addr();
        int unsigned word;
        word = $urandom_range(mem_map_pkg::MEM_WORDS - 1, 0);
        return mem_map_pkg::MEM_BASE + mem_bus_pkg::addr_t'(word * 8)
            + mem_bus_pkg::addr_t'($urandom_range(7, 0));
    endfunction

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic drive_step();
        @(posedge clk);
        #2;
    endtask

    task automatic report_timeout(input string what);
        err_cnt++;
        $display("timeout: no %s within %0d cycles in test %s", what, WAIT_LIMIT, test_name);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_base = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_base) begin
            pass_cnt++;
            $display("test %s passed", test_name);
        end else begin
            fail_cnt++;
            $display("test %s failed with %0d errors", test_name, err_cnt - test_err_base);
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        assert (!fetch_r_valid_o && !lsu_r_valid_o && !lsu_b_valid_o && !lsu_w_ready_o
                && lsu_aw_ready_o && lsu_ar_ready_o && fetch_ar_ready_o)
        else begin
            err_cnt++;
            $display("outputs were not in their reset state in %s", test_name);
        end
        drive_step();
    endtask

    // full aw, w, b sequence, b_ready held low for hold cycles
    task automatic write_word(input mem_bus_pkg::addr_t addr, input mem_bus_pkg::data_t data,
            input mem_bus_pkg::strb_t strb, input int hold);
        logic aw_hs, w_hs, b_hs;
        int stalled, cycles;
        exp_b_resp = expect_resp(addr);
        lsu_aw_valid_i = 1'b1;
        lsu_aw_addr_i = addr;
        lsu_w_valid_i = 1'b1;
        lsu_w_data_i = data;
        lsu_w_strb_i = strb;
        lsu_b_ready_i = (hold == 0);
        b_hs = 1'b0;
        stalled = 0;
        cycles = 0;
        while (!b_hs && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            aw_hs = lsu_aw_valid_i && lsu_aw_ready_o;
            w_hs = lsu_w_valid_i && lsu_w_ready_o;
            b_hs = lsu_b_valid_o && lsu_b_ready_i;
            if (lsu_b_valid_o && !lsu_b_ready_i) begin
                stalled++;
            end
            cycles++;
            drive_step();
            if (aw_hs) begin
                lsu_aw_valid_i = 1'b0;
            end
            if (w_hs) begin
                lsu_w_valid_i = 1'b0;
            end
            if (stalled >= hold) begin
                lsu_b_ready_i = 1'b1;
            end
        end
        if (addr_mapped(addr)) begin
            ref_mem[word_of(addr)] = merge_bytes(ref_mem[word_of(addr)], data, strb);
        end
        if (!b_hs) begin
            report_timeout("write response");
        end
    endtask

    // one read per enabled master, raised together
    task automatic read_pair(input logic do_lsu, input mem_bus_pkg::addr_t lsu_addr,
            input logic do_fetch, input mem_bus_pkg::addr_t fetch_addr, input int hold);
        logic lsu_busy, fetch_busy, lsu_ar_hs, fetch_ar_hs, lsu_r_hs, fetch_r_hs;
        int stalled, cycles;
        lsu_exp_data = expect_data(lsu_addr);
        lsu_exp_resp = expect_resp(lsu_addr);
        fetch_exp_data = expect_data(fetch_addr);
        fetch_exp_resp = expect_resp(fetch_addr);
        lsu_ar_valid_i = do_lsu;
        lsu_ar_addr_i = lsu_addr;
        fetch_ar_valid_i = do_fetch;
        fetch_ar_addr_i = fetch_addr;
        lsu_r_ready_i = (hold == 0);
        fetch_r_ready_i = (hold == 0);
        lsu_busy = do_lsu;
        fetch_busy = do_fetch;
        stalled = 0;
        cycles = 0;
        while ((lsu_busy || fetch_busy) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            lsu_ar_hs = lsu_ar_valid_i && lsu_ar_ready_o;
            fetch_ar_hs = fetch_ar_valid_i && fetch_ar_ready_o;
            lsu_r_hs = lsu_r_valid_o && lsu_r_ready_i;
            fetch_r_hs = fetch_r_valid_o && fetch_r_ready_i;
            if ((lsu_r_valid_o && !lsu_r_ready_i) || (fetch_r_valid_o && !fetch_r_ready_i)) begin
                stalled++;
            end
            cycles++;
            drive_step();
            if (lsu_ar_hs) begin
                lsu_ar_valid_i = 1'b0;
            end
            if (fetch_ar_hs) begin
                fetch_ar_valid_i = 1'b0;
            end
            if (lsu_r_hs) begin
                lsu_busy = 1'b0;
                lsu_r_seen = 1'b1;
            end
            if (fetch_r_hs) begin
                fetch_busy = 1'b0;
            end
            if (stalled >= hold) begin
                lsu_r_ready_i = 1'b1;
                fetch_r_ready_i = 1'b1;
            end
        end
        if (lsu_busy || fetch_busy) begin
            report_timeout("read response");
        end
    endtask

    initial begin
        mem_bus_pkg::addr_t addr;
        void'($urandom(32'h7234_2a50));
        clk = 1'b0;
        arst_n_i = 1'b0;
        fetch_ar_valid_i = 1'b0;
        fetch_ar_addr_i = '0;
        fetch_r_ready_i = 1'b0;
        lsu_ar_valid_i = 1'b0;
        lsu_ar_addr_i = '0;
        lsu_r_ready_i = 1'b0;
        lsu_aw_valid_i = 1'b0;
        lsu_aw_addr_i = '0;
        lsu_w_valid_i = 1'b0;
        lsu_w_data_i = '0;
        lsu_w_strb_i = '0;
        lsu_b_ready_i = 1'b0;
        race = 1'b0;
        lsu_r_seen = 1'b0;
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int i = 0; i < mem_map_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        arst_n_i = 1'b1;

        start_test("reset_state");
        check_reset_state();
        finish_test();

        // full word first, then a partial overwrite
        start_test("strobe_write");
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr();
            written.push_back(addr);
            write_word(addr, {$urandom, $urandom}, '1, 0);
            write_word(addr, {$urandom, $urandom}, mem_bus_pkg::strb_t'($urandom), 0);
            read_pair(1'b1, addr, 1'b0, '0, 0);
        end
        finish_test();

        start_test("fetch_read");
        foreach (written[i]) begin
            read_pair(1'b0, '0, 1'b1, written[i], 0);
        end
        finish_test();

        // outside addresses alias the index bits of written words
        start_test("out_of_window");
        read_pair(1'b1, mem_map_pkg::MEM_BASE - 8, 1'b0, '0, 0);
        read_pair(1'b0, '0, 1'b1, mem_map_pkg::MEM_BASE + WINDOW_BYTES, 0);
        write_word(written[0] - WINDOW_BYTES, {$urandom, $urandom}, '1, 0);
        write_word(written[1] + WINDOW_BYTES, {$urandom, $urandom}, '1, 0);
        read_pair(1'b1, written[0], 1'b0, '0, 0);
        read_pair(1'b0, '0, 1'b1, written[1], 0);
        finish_test();

        start_test("contention");
        race = 1'b1;
        for (int i = 0; i + 1 < written.size(); i++) begin
            lsu_r_seen = 1'b0;
            read_pair(1'b1, written[i], 1'b1, written[i + 1], 0);
        end
        race = 1'b0;
        finish_test();

        start_test("back_pressure");
        write_word(written[2], {$urandom, $urandom}, mem_bus_pkg::strb_t'($urandom), 5);
        read_pair(1'b1, written[2], 1'b0, '0, 4);
        read_pair(1'b0, '0, 1'b1, written[3], 3);
        read_pair(1'b1, written[4], 1'b1, written[5], 2);
        finish_test();

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- mem_subsys.f
common/mem_bus_pkg.sv
common/mem_map_pkg.sv
arbiter/read_arbiter.sv
sram/sram_array.sv
sram/sram_ctrl.sv
logic/mem_subsys.sv
verif/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --top-module tb_mem_subsys -f mem_subsys.f \
    --Mdir "$BUILD_DIR" -o sim_mem_subsys > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_mem_subsys" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
